//--- verilog/id_pkg.sv
// Shared widths, select encodings and instruction word views for the
// operand side of the decode stage. Every RTL file and the testbench refer
// to these by scoped names.

package id_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data and address width
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // Mux select widths
  localparam int OP_A_SEL_W = 2;
  localparam int OP_B_SEL_W = 2;
  localparam int OP_C_SEL_W = 2;
  localparam int IMM_SEL_W  = 3;
  localparam int JT_SEL_W   = 2;

  ////////////////////////////////////////
  // Select encodings
  ////////////////////////////////////////

  // Operand A sources
  localparam logic [OP_A_SEL_W-1:0] OP_A_REG  = 2'd0;
  localparam logic [OP_A_SEL_W-1:0] OP_A_PC   = 2'd1;
  localparam logic [OP_A_SEL_W-1:0] OP_A_ZIMM = 2'd2;
  localparam logic [OP_A_SEL_W-1:0] OP_A_ZERO = 2'd3;

  // Operand B sources
  localparam logic [OP_B_SEL_W-1:0] OP_B_REG  = 2'd0;
  localparam logic [OP_B_SEL_W-1:0] OP_B_REGC = 2'd1;
  localparam logic [OP_B_SEL_W-1:0] OP_B_IMM  = 2'd2;

  // Operand C sources, JT carries the jump target into EX
  localparam logic [OP_C_SEL_W-1:0] OP_C_REG  = 2'd0;
  localparam logic [OP_C_SEL_W-1:0] OP_C_REGB = 2'd1;
  localparam logic [OP_C_SEL_W-1:0] OP_C_JT   = 2'd2;

  // Immediate for operand B
  localparam logic [IMM_SEL_W-1:0] IMM_I      = 3'd0;
  localparam logic [IMM_SEL_W-1:0] IMM_S      = 3'd1;
  localparam logic [IMM_SEL_W-1:0] IMM_U      = 3'd2;
  localparam logic [IMM_SEL_W-1:0] IMM_PCINCR = 3'd3;

  // Jump target offset kinds
  localparam logic [JT_SEL_W-1:0] JT_JAL  = 2'd0;
  localparam logic [JT_SEL_W-1:0] JT_JALR = 2'd1;
  localparam logic [JT_SEL_W-1:0] JT_COND = 2'd2;
  localparam logic [JT_SEL_W-1:0] JT_HWLP = 2'd3;

  ////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////

  // R-type field layout, also covers I/S/B pieces
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_r_view_t;

  // U/J-type layout, upper 20 bits as one field
  typedef struct packed {
    logic [19:0]           imm20;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_u_view_t;

  // Same 32 bits seen both ways
  typedef union packed {
    instr_r_view_t r;
    instr_u_view_t u;
  } instr_word_u;

endpackage

//--- verilog/id_register_file.sv
// 32 x 32-bit integer register file for the decode stage.
// Three combinational read ports, two write ports written on the rising
// clock edge. Port B wins when both ports hit the same register.
// x0 is hardwired to zero and never written.

module id_register_file
(
  input  logic                          clk,
  input  logic                          rst_n,

  // Read ports
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_c_i,
  output logic [id_pkg::XLEN-1:0]       rdata_a_o,
  output logic [id_pkg::XLEN-1:0]       rdata_b_o,
  output logic [id_pkg::XLEN-1:0]       rdata_c_o,

  // Write port A, memory write-back
  input  logic [id_pkg::REG_ADDR_W-1:0] waddr_a_i,
  input  logic [id_pkg::XLEN-1:0]       wdata_a_i,
  input  logic                          we_a_i,

  // Write port B, ALU result
  input  logic [id_pkg::REG_ADDR_W-1:0] waddr_b_i,
  input  logic [id_pkg::XLEN-1:0]       wdata_b_i,
  input  logic                          we_b_i
);

  logic [id_pkg::XLEN-1:0] regs [id_pkg::NUM_REGS];

  // x0 stays zero
  assign regs[0] = '0;

  // One flop word per register, x1 upwards
  for (genvar i = 1; i < id_pkg::NUM_REGS; i++)
  begin : g_reg
    always_ff @(posedge clk, negedge rst_n)
    begin
      if (!rst_n)
        regs[i] <= '0;
      // Port B checked first so it takes priority
      else if (we_b_i && (waddr_b_i == i[id_pkg::REG_ADDR_W-1:0]))
        regs[i] <= wdata_b_i;
      else if (we_a_i && (waddr_a_i == i[id_pkg::REG_ADDR_W-1:0]))
        regs[i] <= wdata_a_i;
    end
  end

  // Combinational reads, x0 via the constant entry
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];
  assign rdata_c_o = regs[raddr_c_i];

endmodule

//--- verilog/id_operand_fetch.sv
// Register operand fetch for the decode stage.
// Pulls rs1, rs2 and rd (used as rs3) out of the instruction, reads the
// register file and resolves forwarding from the ALU and write-back ports.
// The raw rs1 read is also passed out for the JALR target adder.

module id_operand_fetch
(
  input  logic                          clk,
  input  logic                          rst_n,

  input  id_pkg::instr_word_u           instr_i,

  // Memory write-back port
  input  logic [id_pkg::REG_ADDR_W-1:0] waddr_wb_i,
  input  logic                          we_wb_i,
  input  logic [id_pkg::XLEN-1:0]       wdata_wb_i,

  // ALU write port
  input  logic [id_pkg::REG_ADDR_W-1:0] waddr_alu_i,
  input  logic                          we_alu_i,
  input  logic [id_pkg::XLEN-1:0]       wdata_alu_i,

  // Forwarded operands
  output logic [id_pkg::XLEN-1:0]       operand_a_o,
  output logic [id_pkg::XLEN-1:0]       operand_b_o,
  output logic [id_pkg::XLEN-1:0]       operand_c_o,
  // rs1 straight from the register file
  output logic [id_pkg::XLEN-1:0]       rs1_raw_o
);

  // Index 0 = rs1, 1 = rs2, 2 = rs3 (rd field)
  logic [id_pkg::REG_ADDR_W-1:0] raddr [3];
  logic [id_pkg::XLEN-1:0]       rdata [3];
  logic [id_pkg::XLEN-1:0]       fwd   [3];

  assign raddr[0] = instr_i.r.rs1;
  assign raddr[1] = instr_i.r.rs2;
  assign raddr[2] = instr_i.r.rd;

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  id_register_file regfile0
  (
    .clk       ( clk         ),
    .rst_n     ( rst_n       ),
    .raddr_a_i ( raddr[0]    ),
    .raddr_b_i ( raddr[1]    ),
    .raddr_c_i ( raddr[2]    ),
    .rdata_a_o ( rdata[0]    ),
    .rdata_b_o ( rdata[1]    ),
    .rdata_c_o ( rdata[2]    ),
    .waddr_a_i ( waddr_wb_i  ),
    .wdata_a_i ( wdata_wb_i  ),
    .we_a_i    ( we_wb_i     ),
    .waddr_b_i ( waddr_alu_i ),
    .wdata_b_i ( wdata_alu_i ),
    .we_b_i    ( we_alu_i    )
  );

  ////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////

  // ALU result beats write-back, x0 never forwarded
  always_comb
  begin
    for (int i = 0; i < 3; i++)
    begin
      if ((raddr[i] != '0) && we_alu_i && (raddr[i] == waddr_alu_i))
        fwd[i] = wdata_alu_i;
      else if ((raddr[i] != '0) && we_wb_i && (raddr[i] == waddr_wb_i))
        fwd[i] = wdata_wb_i;
      else
        fwd[i] = rdata[i];
    end
  end

  assign operand_a_o = fwd[0];
  assign operand_b_o = fwd[1];
  assign operand_c_o = fwd[2];
  // Short path for the jump adder, no forwarding
  assign rs1_raw_o   = rdata[0];

endmodule

//--- verilog/id_imm_gen.sv
// Immediate generation for the decode stage.
// Builds the RISC-V I, S, SB, U and UJ immediates plus the zero-extended
// rs1 immediate, then picks the operand B immediate and the jump offset
// from the select inputs. Purely combinational.

module id_imm_gen
(
  input  id_pkg::instr_word_u          instr_i,
  input  logic                         is_compressed_i,
  input  logic [id_pkg::IMM_SEL_W-1:0] imm_sel_i,
  input  logic [id_pkg::JT_SEL_W-1:0]  jt_sel_i,

  output logic [id_pkg::XLEN-1:0]      immediate_b_o,
  output logic [id_pkg::XLEN-1:0]      imm_z_o,
  output logic [id_pkg::XLEN-1:0]      jt_offset_o
);

  logic [id_pkg::XLEN-1:0] imm_i;
  logic [id_pkg::XLEN-1:0] imm_s;
  logic [id_pkg::XLEN-1:0] imm_sb;
  logic [id_pkg::XLEN-1:0] imm_u;
  logic [id_pkg::XLEN-1:0] imm_uj;
  logic                    sign;

  // Sign bit is always instr[31]
  assign sign = instr_i.r.funct7[6];

  ////////////////////////////////////////
  // Extraction
  ////////////////////////////////////////

  // instr[31:20]
  assign imm_i  = {{20{sign}}, instr_i.r.funct7, instr_i.r.rs2};
  // instr[31:25] and instr[11:7]
  assign imm_s  = {{20{sign}}, instr_i.r.funct7, instr_i.r.rd};
  // Branch offset, bit 11 lives in instr[7]
  assign imm_sb = {{19{sign}}, sign, instr_i.r.rd[0], instr_i.r.funct7[5:0],
                   instr_i.r.rd[4:1], 1'b0};
  // Upper immediate from the U view
  assign imm_u  = {instr_i.u.imm20, 12'b0};
  // JAL offset, scrambled inside imm20
  assign imm_uj = {{12{instr_i.u.imm20[19]}}, instr_i.u.imm20[7:0],
                   instr_i.u.imm20[8], instr_i.u.imm20[18:9], 1'b0};

  // CSR style immediate in the rs1 slot
  assign imm_z_o = {{(id_pkg::XLEN - id_pkg::REG_ADDR_W){1'b0}}, instr_i.r.rs1};

  ////////////////////////////////////////
  // Selection
  ////////////////////////////////////////

  // Operand B immediate
  always_comb
  begin
    case (imm_sel_i)
      id_pkg::IMM_I:      immediate_b_o = imm_i;
      id_pkg::IMM_S:      immediate_b_o = imm_s;
      id_pkg::IMM_U:      immediate_b_o = imm_u;
      // Link address step, 2 for compressed
      id_pkg::IMM_PCINCR: immediate_b_o = is_compressed_i ? 32'd2 : 32'd4;
      default:            immediate_b_o = imm_i;
    endcase
  end

  // Jump target offset
  always_comb
  begin
    case (jt_sel_i)
      id_pkg::JT_JAL:  jt_offset_o = imm_uj;
      id_pkg::JT_JALR: jt_offset_o = imm_i;
      id_pkg::JT_COND: jt_offset_o = imm_sb;
      // Hardware loop setup, PC relative I immediate
      default:         jt_offset_o = imm_i;
    endcase
  end

endmodule

//--- verilog/id_operand_select.sv
// Operand selection and ID/EX pipeline register.
// Forms the jump target, muxes ALU operands A, B and C from registers,
// PC and immediates, and registers them for EX. The register loads on
// id_valid_i; with only ex_ready_i high the write enable and valid clear
// while the operands hold; with ex_ready_i low everything holds.

module id_operand_select
(
  input  logic                          clk,
  input  logic                          rst_n,

  // Data sources
  input  logic [id_pkg::XLEN-1:0]       pc_id_i,
  input  logic [id_pkg::XLEN-1:0]       operand_a_i,
  input  logic [id_pkg::XLEN-1:0]       operand_b_i,
  input  logic [id_pkg::XLEN-1:0]       operand_c_i,
  input  logic [id_pkg::XLEN-1:0]       rs1_raw_i,
  input  logic [id_pkg::XLEN-1:0]       immediate_b_i,
  input  logic [id_pkg::XLEN-1:0]       imm_z_i,
  input  logic [id_pkg::XLEN-1:0]       jt_offset_i,

  // Mux selects
  input  logic [id_pkg::JT_SEL_W-1:0]   jt_sel_i,
  input  logic [id_pkg::OP_A_SEL_W-1:0] op_a_sel_i,
  input  logic [id_pkg::OP_B_SEL_W-1:0] op_b_sel_i,
  input  logic [id_pkg::OP_C_SEL_W-1:0] op_c_sel_i,

  // Write-back info and flow control
  input  logic [id_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic                          regfile_we_i,
  input  logic                          id_valid_i,
  input  logic                          ex_ready_i,

  output logic [id_pkg::XLEN-1:0]       jump_target_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_a_ex_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_b_ex_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_c_ex_o,
  output logic [id_pkg::REG_ADDR_W-1:0] regfile_waddr_ex_o,
  output logic                          regfile_we_ex_o,
  output logic                          valid_ex_o
);

  logic [id_pkg::XLEN-1:0] jt_base;
  logic [id_pkg::XLEN-1:0] alu_operand_a;
  logic [id_pkg::XLEN-1:0] alu_operand_b;
  logic [id_pkg::XLEN-1:0] alu_operand_c;

  ////////////////////////////////////////
  // Jump target
  ////////////////////////////////////////

  // JALR is register relative, all others PC relative
  assign jt_base       = (jt_sel_i == id_pkg::JT_JALR) ? rs1_raw_i : pc_id_i;
  assign jump_target_o = jt_base + jt_offset_i;

  ////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////

  always_comb
  begin
    case (op_a_sel_i)
      id_pkg::OP_A_REG:  alu_operand_a = operand_a_i;
      id_pkg::OP_A_PC:   alu_operand_a = pc_id_i;
      id_pkg::OP_A_ZIMM: alu_operand_a = imm_z_i;
      default:           alu_operand_a = '0;
    endcase
  end

  always_comb
  begin
    case (op_b_sel_i)
      // rs3 swapped into B
      id_pkg::OP_B_REGC: alu_operand_b = operand_c_i;
      id_pkg::OP_B_IMM:  alu_operand_b = immediate_b_i;
      default:           alu_operand_b = operand_b_i;
    endcase
  end

  always_comb
  begin
    case (op_c_sel_i)
      // rs2 swapped into C
      id_pkg::OP_C_REGB: alu_operand_c = operand_b_i;
      // Link or branch target for EX
      id_pkg::OP_C_JT:   alu_operand_c = jump_target_o;
      default:           alu_operand_c = operand_c_i;
    endcase
  end

  ////////////////////////////////////////
  // ID/EX pipeline register
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      alu_operand_a_ex_o <= '0;
      alu_operand_b_ex_o <= '0;
      alu_operand_c_ex_o <= '0;
      regfile_waddr_ex_o <= '0;
      regfile_we_ex_o    <= 1'b0;
      valid_ex_o         <= 1'b0;
    end
    else if (id_valid_i)
    begin
      alu_operand_a_ex_o <= alu_operand_a;
      alu_operand_b_ex_o <= alu_operand_b;
      alu_operand_c_ex_o <= alu_operand_c;
      regfile_waddr_ex_o <= rd_i;
      regfile_we_ex_o    <= regfile_we_i;
      valid_ex_o         <= 1'b1;
    end
    else if (ex_ready_i)
    begin
      // Bubble into EX, operands keep stale data
      regfile_we_ex_o <= 1'b0;
      valid_ex_o      <= 1'b0;
    end
  end

endmodule

//--- verilog/id_stage.sv
// Top level of the decode stage operand path.
// Operand fetch and immediate generation run in parallel on the current
// instruction; operand selection combines them and feeds the ID/EX
// register. Mux selects and the write enable come in as plain levels.

module id_stage
(
  input  logic                          clk,
  input  logic                          rst_n,

  // Instruction from IF
  input  id_pkg::instr_word_u           instr_i,
  input  logic [id_pkg::XLEN-1:0]       pc_id_i,
  input  logic                          is_compressed_i,

  // Decoded controls
  input  logic [id_pkg::OP_A_SEL_W-1:0] op_a_sel_i,
  input  logic [id_pkg::OP_B_SEL_W-1:0] op_b_sel_i,
  input  logic [id_pkg::OP_C_SEL_W-1:0] op_c_sel_i,
  input  logic [id_pkg::IMM_SEL_W-1:0]  imm_sel_i,
  input  logic [id_pkg::JT_SEL_W-1:0]   jt_sel_i,
  input  logic                          regfile_we_i,

  // Flow control
  input  logic                          instr_valid_i,
  input  logic                          ex_ready_i,

  // Write port A, memory write-back
  input  logic [id_pkg::REG_ADDR_W-1:0] waddr_wb_i,
  input  logic                          we_wb_i,
  input  logic [id_pkg::XLEN-1:0]       wdata_wb_i,

  // Write port B, ALU
  input  logic [id_pkg::REG_ADDR_W-1:0] waddr_alu_i,
  input  logic                          we_alu_i,
  input  logic [id_pkg::XLEN-1:0]       wdata_alu_i,

  output logic                          id_valid_o,
  output logic [id_pkg::XLEN-1:0]       jump_target_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_a_ex_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_b_ex_o,
  output logic [id_pkg::XLEN-1:0]       alu_operand_c_ex_o,
  output logic [id_pkg::REG_ADDR_W-1:0] regfile_waddr_ex_o,
  output logic                          regfile_we_ex_o,
  output logic                          valid_ex_o
);

  logic [id_pkg::XLEN-1:0] operand_a;
  logic [id_pkg::XLEN-1:0] operand_b;
  logic [id_pkg::XLEN-1:0] operand_c;
  logic [id_pkg::XLEN-1:0] rs1_raw;
  logic [id_pkg::XLEN-1:0] immediate_b;
  logic [id_pkg::XLEN-1:0] imm_z;
  logic [id_pkg::XLEN-1:0] jt_offset;

  // Instruction moves on only when EX can take it
  assign id_valid_o = instr_valid_i & ex_ready_i;

  ////////////////////////////////////////
  // Register operands
  ////////////////////////////////////////

  id_operand_fetch fetch0
  (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .instr_i     ( instr_i     ),
    .waddr_wb_i  ( waddr_wb_i  ),
    .we_wb_i     ( we_wb_i     ),
    .wdata_wb_i  ( wdata_wb_i  ),
    .waddr_alu_i ( waddr_alu_i ),
    .we_alu_i    ( we_alu_i    ),
    .wdata_alu_i ( wdata_alu_i ),
    .operand_a_o ( operand_a   ),
    .operand_b_o ( operand_b   ),
    .operand_c_o ( operand_c   ),
    .rs1_raw_o   ( rs1_raw     )
  );

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////

  id_imm_gen imm0
  (
    .instr_i         ( instr_i         ),
    .is_compressed_i ( is_compressed_i ),
    .imm_sel_i       ( imm_sel_i       ),
    .jt_sel_i        ( jt_sel_i        ),
    .immediate_b_o   ( immediate_b     ),
    .imm_z_o         ( imm_z           ),
    .jt_offset_o     ( jt_offset       )
  );

  ////////////////////////////////////////
  // Select and pipe
  ////////////////////////////////////////

  id_operand_select select0
  (
    .clk                ( clk                ),
    .rst_n              ( rst_n              ),
    .pc_id_i            ( pc_id_i            ),
    .operand_a_i        ( operand_a          ),
    .operand_b_i        ( operand_b          ),
    .operand_c_i        ( operand_c          ),
    .rs1_raw_i          ( rs1_raw            ),
    .immediate_b_i      ( immediate_b        ),
    .imm_z_i            ( imm_z              ),
    .jt_offset_i        ( jt_offset          ),
    .jt_sel_i           ( jt_sel_i           ),
    .op_a_sel_i         ( op_a_sel_i         ),
    .op_b_sel_i         ( op_b_sel_i         ),
    .op_c_sel_i         ( op_c_sel_i         ),
    // Destination straight from the rd field
    .rd_i               ( instr_i.r.rd       ),
    .regfile_we_i       ( regfile_we_i       ),
    .id_valid_i         ( id_valid_o         ),
    .ex_ready_i         ( ex_ready_i         ),
    .jump_target_o      ( jump_target_o      ),
    .alu_operand_a_ex_o ( alu_operand_a_ex_o ),
    .alu_operand_b_ex_o ( alu_operand_b_ex_o ),
    .alu_operand_c_ex_o ( alu_operand_c_ex_o ),
    .regfile_waddr_ex_o ( regfile_waddr_ex_o ),
    .regfile_we_ex_o    ( regfile_we_ex_o    ),
    .valid_ex_o         ( valid_ex_o         )
  );

endmodule

//--- bench/tb_id_stage.sv
// Random testbench for the decode stage operand path.
// Drives id_stage with seeded random instructions, selects and register
// writes, and checks every output against a shadow register file and a
// shadow ID/EX register kept in this module. Ends on its own.

module tb_id_stage;

  timeunit 1ns;
  timeprecision 100ps;

  // Phase lengths in clock cycles
  localparam int RESET_CYCLES    = 8;
  localparam int WRITE_CYCLES    = 200;
  localparam int READ_CYCLES     = 200;
  localparam int FWD_CYCLES      = 600;
  localparam int MIXED_CYCLES    = 1000;
  localparam int STALL_ROUNDS    = 4;
  localparam int DIRECTED_CYCLES = 2 + STALL_ROUNDS * 8;
  localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + WRITE_CYCLES + READ_CYCLES
                                        + FWD_CYCLES + MIXED_CYCLES + DIRECTED_CYCLES);

  // Stimulus flavours
  localparam int MODE_WRITE = 0;
  localparam int MODE_READ  = 1;
  localparam int MODE_FWD   = 2;
  localparam int MODE_MIXED = 3;

  logic                          clk;
  logic                          rst_n;
  id_pkg::instr_word_u           instr;
  logic [id_pkg::XLEN-1:0]       pc_id;
  logic                          is_compressed;
  logic [id_pkg::OP_A_SEL_W-1:0] op_a_sel;
  logic [id_pkg::OP_B_SEL_W-1:0] op_b_sel;
  logic [id_pkg::OP_C_SEL_W-1:0] op_c_sel;
  logic [id_pkg::IMM_SEL_W-1:0]  imm_sel;
  logic [id_pkg::JT_SEL_W-1:0]   jt_sel;
  logic                          regfile_we;
  logic                          instr_valid;
  logic                          ex_ready;
  logic [id_pkg::REG_ADDR_W-1:0] waddr_wb;
  logic                          we_wb;
  logic [id_pkg::XLEN-1:0]       wdata_wb;
  logic [id_pkg::REG_ADDR_W-1:0] waddr_alu;
  logic                          we_alu;
  logic [id_pkg::XLEN-1:0]       wdata_alu;

  logic                          id_valid;
  logic [id_pkg::XLEN-1:0]       jump_target;
  logic [id_pkg::XLEN-1:0]       op_a_ex;
  logic [id_pkg::XLEN-1:0]       op_b_ex;
  logic [id_pkg::XLEN-1:0]       op_c_ex;
  logic [id_pkg::REG_ADDR_W-1:0] waddr_ex;
  logic                          we_ex;
  logic                          valid_ex;

  // Reference model state
  logic [id_pkg::XLEN-1:0]       shadow_regs [id_pkg::NUM_REGS];
  logic [id_pkg::XLEN-1:0]       exp_a;
  logic [id_pkg::XLEN-1:0]       exp_b;
  logic [id_pkg::XLEN-1:0]       exp_c;
  logic [id_pkg::REG_ADDR_W-1:0] exp_waddr;
  logic                          exp_we;
  logic                          exp_valid;
  // Values the pipe should load at the next edge
  logic [id_pkg::XLEN-1:0]       nxt_a;
  logic [id_pkg::XLEN-1:0]       nxt_b;
  logic [id_pkg::XLEN-1:0]       nxt_c;
  logic [id_pkg::XLEN-1:0]       nxt_jt;
  logic [id_pkg::REG_ADDR_W-1:0] nxt_rd;
  int                            cycle_count = 0;

  id_stage dut0
  (
    .clk                ( clk           ),
    .rst_n              ( rst_n         ),
    .instr_i            ( instr         ),
    .pc_id_i            ( pc_id         ),
    .is_compressed_i    ( is_compressed ),
    .op_a_sel_i         ( op_a_sel      ),
    .op_b_sel_i         ( op_b_sel      ),
    .op_c_sel_i         ( op_c_sel      ),
    .imm_sel_i          ( imm_sel       ),
    .jt_sel_i           ( jt_sel        ),
    .regfile_we_i       ( regfile_we    ),
    .instr_valid_i      ( instr_valid   ),
    .ex_ready_i         ( ex_ready      ),
    .waddr_wb_i         ( waddr_wb      ),
    .we_wb_i            ( we_wb         ),
    .wdata_wb_i         ( wdata_wb      ),
    .waddr_alu_i        ( waddr_alu     ),
    .we_alu_i           ( we_alu        ),
    .wdata_alu_i        ( wdata_alu     ),
    .id_valid_o         ( id_valid      ),
    .jump_target_o      ( jump_target   ),
    .alu_operand_a_ex_o ( op_a_ex       ),
    .alu_operand_b_ex_o ( op_b_ex       ),
    .alu_operand_c_ex_o ( op_c_ex       ),
    .regfile_waddr_ex_o ( waddr_ex      ),
    .regfile_we_ex_o    ( we_ex         ),
    .valid_ex_o         ( valid_ex      )
  );

  // 40 ns clock
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Runaway guard
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES)
      fail_run($sformatf("timeout after %0d clock cycles", cycle_count));
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input logic [id_pkg::XLEN-1:0] got,
                            input logic [id_pkg::XLEN-1:0] exp, input string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s is %h, expected %h", $realtime, what, got, exp));
  endtask

  task automatic check_addr(input logic [id_pkg::REG_ADDR_W-1:0] got,
                            input logic [id_pkg::REG_ADDR_W-1:0] exp, input string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $realtime, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_run($sformatf("error at %0t: %s is %b, expected %b", $realtime, what, got, exp));
  endtask

  // Pipe outputs against the shadow pipe
  task automatic check_pipe();
    check_word(op_a_ex, exp_a, "alu_operand_a_ex");
    check_word(op_b_ex, exp_b, "alu_operand_b_ex");
    check_word(op_c_ex, exp_c, "alu_operand_c_ex");
    check_addr(waddr_ex, exp_waddr, "regfile_waddr_ex");
    check_bit(we_ex, exp_we, "regfile_we_ex");
    check_bit(valid_ex, exp_valid, "valid_ex");
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Register read through ALU then WB forwarding
  // x0 is never forwarded
  function automatic logic [id_pkg::XLEN-1:0] read_fwd(input logic [4:0] addr);
    if (addr != 5'd0 && we_alu && addr == waddr_alu)
      return wdata_alu;
    if (addr != 5'd0 && we_wb && addr == waddr_wb)
      return wdata_wb;
    return shadow_regs[addr];
  endfunction

  // Next pipe contents from the inputs of this cycle
  task automatic evaluate_model();
    logic [31:0]             w;
    logic [id_pkg::XLEN-1:0] imm_i;
    logic [id_pkg::XLEN-1:0] imm_s;
    logic [id_pkg::XLEN-1:0] imm_sb;
    logic [id_pkg::XLEN-1:0] imm_u;
    logic [id_pkg::XLEN-1:0] imm_uj;
    logic [id_pkg::XLEN-1:0] imm_b;
    logic [id_pkg::XLEN-1:0] offset;
    w      = instr;
    imm_i  = {{20{w[31]}}, w[31:20]};
    imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_sb = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u  = {w[31:12], 12'b0};
    imm_uj = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    case (imm_sel)
      id_pkg::IMM_S:      imm_b = imm_s;
      id_pkg::IMM_U:      imm_b = imm_u;
      id_pkg::IMM_PCINCR: imm_b = is_compressed ? 32'd2 : 32'd4;
      default:            imm_b = imm_i;
    endcase
    case (jt_sel)
      id_pkg::JT_JAL:  offset = imm_uj;
      id_pkg::JT_COND: offset = imm_sb;
      default:         offset = imm_i;
    endcase
    // JALR base is the raw register without forwarding
    if (jt_sel == id_pkg::JT_JALR)
      nxt_jt = shadow_regs[w[19:15]] + offset;
    else
      nxt_jt = pc_id + offset;
    case (op_a_sel)
      id_pkg::OP_A_REG:  nxt_a = read_fwd(w[19:15]);
      id_pkg::OP_A_PC:   nxt_a = pc_id;
      id_pkg::OP_A_ZIMM: nxt_a = {27'b0, w[19:15]};
      default:           nxt_a = '0;
    endcase
    case (op_b_sel)
      id_pkg::OP_B_REGC: nxt_b = read_fwd(w[11:7]);
      id_pkg::OP_B_IMM:  nxt_b = imm_b;
      default:           nxt_b = read_fwd(w[24:20]);
    endcase
    case (op_c_sel)
      id_pkg::OP_C_REGB: nxt_c = read_fwd(w[24:20]);
      id_pkg::OP_C_JT:   nxt_c = nxt_jt;
      default:           nxt_c = read_fwd(w[11:7]);
    endcase
    nxt_rd = w[11:7];
  endtask

  // Clock edge moves the pipe under the stall rule and then writes registers
  task automatic update_model();
    if (instr_valid && ex_ready)
    begin
      exp_a     = nxt_a;
      exp_b     = nxt_b;
      exp_c     = nxt_c;
      exp_waddr = nxt_rd;
      exp_we    = regfile_we;
      exp_valid = 1'b1;
    end
    else if (ex_ready)
    begin
      exp_we    = 1'b0;
      exp_valid = 1'b0;
    end
    if (we_wb && waddr_wb != 5'd0)
      shadow_regs[waddr_wb] = wdata_wb;
    // ALU port last so it wins a conflict
    if (we_alu && waddr_alu != 5'd0)
      shadow_regs[waddr_alu] = wdata_alu;
  endtask

  // Check mid-cycle and advance the model on the edge
  task automatic run_cycle();
    @(negedge clk);
    check_pipe();
    evaluate_model();
    check_word(jump_target, nxt_jt, "jump_target");
    check_bit(id_valid, instr_valid & ex_ready, "id_valid");
    @(posedge clk);
    update_model();
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // New inputs right after a rising edge
  task automatic drive_random(input int mode);
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  fields [3];
    w = $urandom;
    r = $urandom;
    s = $urandom;
    fields[0] = w[19:15];
    fields[1] = w[24:20];
    fields[2] = w[11:7];
    instr         <= w;
    pc_id         <= $urandom;
    is_compressed <= r[0];
    op_a_sel      <= r[2:1];
    op_b_sel      <= (r[4:3] == 2'd3) ? id_pkg::OP_B_IMM : r[4:3];
    op_c_sel      <= (r[6:5] == 2'd3) ? id_pkg::OP_C_JT : r[6:5];
    imm_sel       <= {1'b0, r[8:7]};
    jt_sel        <= r[10:9];
    regfile_we    <= r[11];
    wdata_wb      <= $urandom;
    wdata_alu     <= $urandom;
    waddr_wb      <= s[4:0];
    // One in four ALU writes hit the WB address
    waddr_alu     <= (s[11:10] == 2'd0) ? s[4:0] : s[9:5];
    we_wb         <= (s[13:12] != 2'd0);
    we_alu        <= (s[15:14] != 2'd0);
    instr_valid   <= s[16];
    ex_ready      <= (s[18:17] != 2'd0);
    case (mode)
      MODE_WRITE:
      begin
        instr_valid <= 1'b0;
        ex_ready    <= 1'b1;
      end
      MODE_READ:
      begin
        op_a_sel    <= id_pkg::OP_A_REG;
        we_wb       <= 1'b0;
        we_alu      <= 1'b0;
        instr_valid <= 1'b1;
        ex_ready    <= 1'b1;
      end
      MODE_FWD:
      begin
        // Aim both write ports at source fields of the new word
        waddr_wb    <= fields[s[20:19] % 3];
        waddr_alu   <= fields[s[22:21] % 3];
        op_a_sel    <= id_pkg::OP_A_REG;
        instr_valid <= 1'b1;
        ex_ready    <= 1'b1;
      end
      default:
      begin
      end
    endcase
  endtask

  initial
  begin
    void'($urandom(32'h8a624604));
    $timeformat(-9, 1, " ns", 0);
    rst_n         = 1'b0;
    instr         = '0;
    pc_id         = '0;
    is_compressed = 1'b0;
    op_a_sel      = '0;
    op_b_sel      = '0;
    op_c_sel      = '0;
    imm_sel       = '0;
    jt_sel        = '0;
    regfile_we    = 1'b0;
    instr_valid   = 1'b0;
    ex_ready      = 1'b0;
    waddr_wb      = '0;
    we_wb         = 1'b0;
    wdata_wb      = '0;
    waddr_alu     = '0;
    we_alu        = 1'b0;
    wdata_alu     = '0;
    for (int i = 0; i < id_pkg::NUM_REGS; i++)
      shadow_regs[i] = '0;
    exp_a     = '0;
    exp_b     = '0;
    exp_c     = '0;
    exp_waddr = '0;
    exp_we    = 1'b0;
    exp_valid = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Pipe comes out of reset cleared
    @(negedge clk);
    check_pipe();
    @(posedge clk);

    // Fill registers and read them back without forwarding
    for (int i = 0; i < WRITE_CYCLES; i++)
    begin
      drive_random(MODE_WRITE);
      run_cycle();
    end
    for (int i = 0; i < READ_CYCLES; i++)
    begin
      drive_random(MODE_READ);
      run_cycle();
    end

    // Same-cycle writes onto the source fields
    for (int i = 0; i < FWD_CYCLES; i++)
    begin
      drive_random(MODE_FWD);
      run_cycle();
    end

    // Everything random including stalls
    for (int i = 0; i < MIXED_CYCLES; i++)
    begin
      drive_random(MODE_MIXED);
      run_cycle();
    end

    // Load and hold under back-pressure before a bubble
    for (int round = 0; round < STALL_ROUNDS; round++)
    begin
      drive_random(MODE_READ);
      regfile_we <= 1'b1;
      run_cycle();
      repeat (4)
      begin
        drive_random(MODE_MIXED);
        ex_ready <= 1'b0;
        run_cycle();
      end
      repeat (3)
      begin
        drive_random(MODE_MIXED);
        instr_valid <= 1'b0;
        ex_ready    <= 1'b1;
        run_cycle();
      end
    end
    @(negedge clk);
    check_pipe();

    $display("Regression passed");
    $finish;
  end

endmodule

//--- vlog.f
verilog/id_pkg.sv
verilog/id_register_file.sv
verilog/id_operand_fetch.sv
verilog/id_imm_gen.sv
verilog/id_operand_select.sv
verilog/id_stage.sv
bench/tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0
TOP       ?= tb_id_stage
FILELIST  ?= vlog.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
